//--- verif/taylor_cases.txt
# columns: sample x (Q3.15 hex), expected result (Q3.24 hex), output code, burst flag
# expected values follow 4th order Horner with truncating shifts
00000 1000000 1 0
08000 2B55554 1 0
78000 0600000 1 0
04000 1A5FFFF 1 0
7C000 09B5555 1 0
10000 6FFFFF0 1 0
70000 0555550 1 0
02000 148B555 1 0
0C000 465FFF8 1 0
18000 7FFFFFF 2 0
20000 7FFFFFF 2 0
60000 4FFFF80 1 0
68000 15FFFDC 1 0
00001 1000200 1 0
7FFFF 0FFFE00 1 0
1FFFF 7FFFFFF 2 0
08000 2B55554 1 1
20000 7FFFFFF 2 1
78000 0600000 1 1
10000 6FFFFF0 1 1
60000 4FFFF80 1 1
00000 1000000 1 1
3FFFF 7FFFFFF 2 1
04000 1A5FFFF 1 1
40000 7FFFFFF 2 0
14000 7FFFFFF 2 0
7C000 09B5555 1 0
68000 15FFFDC 1 0
02000 148B555 1 0
0C000 465FFF8 1 0
7FFFF 0FFFE00 1 1
00001 1000200 1 1

//--- flist.f
+incdir+logic
logic/mc_pkg.sv
logic/reset_sequencer.sv
logic/taylor_core.sv
logic/core_arbiter.sv
logic/multicore.sv
verif/mc_clock_gen.sv
verif/multicore_asserts.sv
verif/multicore_tb.sv

//--- Makefile
# Verilator build and run for the multicore Taylor evaluator

VERILATOR ?= verilator
TOP ?= multicore_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= all tests passed

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/multicore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module multicore_tb;
	import mc_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int NC = `MC_NUM_CORES;
	localparam int LATENCY = 5; // load edge to out_en

	logic clk;
	logic rst_n;
	sample_t io_in;
	logic in_load;
	logic req_any;
	core_idx_t req_core;
	result_t io_out;
	code_t out_en;
	core_idx_t out_core;

	sample_t case_x [MAX_CASES];
	result_t case_y [MAX_CASES];
	code_t case_code [MAX_CASES];
	bit case_burst [MAX_CASES];
	bit case_done [MAX_CASES];
	int n_cases = 0;

	int core_case [NC];
	bit core_busy [NC];
	int core_load_cyc [NC];
	int first_req [NC];

	int cycle = 0;
	int timeout_limit = 1000000;
	int next_case = 0;
	int delivered = 0;
	int wait_left = 0;
	bit prev_out = 1'b0;
	int value_errs = 0;
	int timing_errs = 0;
	int other_errs = 0;

	mc_clock_gen u_clk (
		.clk(clk),
		.rst_n(rst_n)
	);

	multicore u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.io_in(io_in),
		.in_load(in_load),
		.req_any(req_any),
		.req_core(req_core),
		.io_out(io_out),
		.out_en(out_en),
		.out_core(out_core)
	);

	always @(posedge clk) begin
		if (rst_n)
			cycle <= cycle + 1;
	end

	always @(posedge clk) begin
		if (rst_n && cycle >= timeout_limit) begin
			$display("timeout after %0d cycles, %0d of %0d results delivered",
				cycle, delivered, n_cases);
			$display("tests failed");
			$finish;
		end
	end

	task automatic read_cases();
		int fd;
		int n;
		int xv, yv, cv, bv;
		string line;
		fd = $fopen("verif/taylor_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the cases file");
			other_errs++;
			return;
		end
		while (!$feof(fd) && n_cases < MAX_CASES) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h", xv, yv, cv, bv);
			if (n != 4)
				continue;
			case_x[n_cases] = sample_t'(xv);
			case_y[n_cases] = result_t'(yv);
			case_code[n_cases] = code_t'(cv);
			case_burst[n_cases] = (bv != 0);
			case_done[n_cases] = 1'b0;
			n_cases++;
		end
		$fclose(fd);
	endtask

	// core k releases at edge STAGGER*k+1 and requests one cycle later
	task automatic check_startup();
		for (int k = 0; k < NC; k++) begin
			if (first_req[k] < 0 && u_dut.req_code[k] == REQ_SAMPLE) begin
				first_req[k] = cycle;
				assert (cycle == `MC_STAGGER_CYCLES * k + 2) else begin
					$display("core %0d first requested at cycle %0d, expected %0d",
						k, cycle, `MC_STAGGER_CYCLES * k + 2);
					timing_errs++;
				end
			end
		end
		if (cycle < 2) begin
			assert (!req_any && out_en == CODE_NONE) else begin
				$display("request or output active before the first core release");
				other_errs++;
			end
		end
	endtask

	task automatic check_result();
		int k;
		int c;
		int lat;
		if (out_en != CODE_NONE) begin
			k = int'(out_core);
			assert (core_busy[k]) else begin
				$display("result from core %0d which holds no case", k);
				other_errs++;
			end
			if (core_busy[k]) begin
				c = core_case[k];
				assert (io_out == case_y[c]) else begin
					$display("FAIL io_out core %0d case %0d exp %h got %h",
						k, c, case_y[c], io_out);
					value_errs++;
				end
				assert (out_en == case_code[c]) else begin
					$display("FAIL out_en core %0d case %0d exp %h got %h",
						k, c, case_code[c], out_en);
					value_errs++;
				end
				assert (!case_done[c]) else begin
					$display("case %0d delivered twice", c);
					other_errs++;
				end
				case_done[c] = 1'b1;
				delivered++;
				lat = cycle - core_load_cyc[k];
				assert (lat == LATENCY || (lat > LATENCY && prev_out)) else begin
					$display("core %0d result after %0d cycles with a free bus", k, lat);
					timing_errs++;
				end
				for (int j = 0; j < k; j++) begin
					assert (!(core_busy[j] && cycle >= core_load_cyc[j] + LATENCY)) else begin
						$display("core %0d delivered while lower core %0d waits", k, j);
						timing_errs++;
					end
				end
				core_busy[k] = 1'b0;
			end
			if (out_en == OUT_SATURATED) begin
				assert (io_out == 28'h7ffffff || io_out == 28'h8000000) else begin
					$display("FAIL io_out saturated exp %h or %h got %h",
						28'h7ffffff, 28'h8000000, io_out);
					value_errs++;
				end
			end
		end else begin
			assert (io_out == '0) else begin
				$display("FAIL io_out idle exp %h got %h", 28'h0, io_out);
				value_errs++;
			end
			for (int j = 0; j < NC; j++) begin
				assert (!(core_busy[j] && cycle >= core_load_cyc[j] + LATENCY)) else begin
					$display("core %0d result ready but bus idle", j);
					timing_errs++;
				end
			end
		end
		prev_out = (out_en != CODE_NONE);
	endtask

	task automatic serve_request();
		int k;
		in_load = 1'b0;
		if (wait_left > 0) begin
			wait_left--;
		end else if (req_any && next_case < n_cases) begin
			k = int'(req_core);
			assert (!core_busy[k]) else begin
				$display("core %0d requests while still holding a case", k);
				other_errs++;
			end
			io_in = case_x[next_case];
			in_load = 1'b1;
			core_case[k] = next_case;
			core_busy[k] = 1'b1;
			core_load_cyc[k] = cycle + 1; // taken at the next rising edge
			next_case++;
			if (next_case < n_cases && !case_burst[next_case])
				wait_left = int'($urandom % 4);
			else
				wait_left = 0;
		end
	endtask

	initial begin
		io_in = '0;
		in_load = 1'b0;
		void'($urandom(8009));
		for (int k = 0; k < NC; k++) begin
			core_busy[k] = 1'b0;
			core_case[k] = 0;
			core_load_cyc[k] = 0;
			first_req[k] = -1;
		end
		read_cases();
		if (n_cases == 0) begin
			$display("no cases read");
			other_errs++;
		end
		timeout_limit = n_cases * 40 + 4 * `MC_STAGGER_CYCLES + 50;
		@(posedge rst_n);
		while (delivered < n_cases) begin
			@(negedge clk);
			check_startup();
			check_result();
			serve_request();
		end
		for (int c = 0; c < n_cases; c++) begin
			assert (case_done[c]) else begin
				$display("case %0d never delivered", c);
				other_errs++;
			end
		end
		for (int k = 0; k < NC; k++) begin
			assert (first_req[k] >= 0) else begin
				$display("core %0d never requested a sample", k);
				timing_errs++;
			end
		end
		other_errs += u_dut.u_asserts.fail_count;
		$display("errors: value %0d, timing %0d, other %0d, total %0d",
			value_errs, timing_errs, other_errs, value_errs + timing_errs + other_errs);
		if (value_errs + timing_errs + other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/multicore_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module multicore_asserts (
	input logic clk,
	input logic rst_n,
	input logic in_load,
	input logic req_any,
	input logic [`MC_NUM_CORES-1:0] load,
	input logic [`MC_NUM_CORES-1:0] grant,
	input logic [3:0] out_en
);

	int fail_count = 0; // read by the testbench summary

	// a sample strobe needs a waiting core
	a_load_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		in_load |-> req_any)
		else begin
			$error("in_load high while no core requests a sample");
			fail_count++;
		end

	a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(load))
		else begin
			$error("more than one core loaded in the same cycle");
			fail_count++;
		end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant))
		else begin
			$error("more than one core granted in the same cycle");
			fail_count++;
		end

	a_out_en_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_en))
		else begin
			$error("out_en unknown after reset");
			fail_count++;
		end

endmodule

bind multicore multicore_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.in_load(in_load),
	.req_any(req_any),
	.load(load),
	.grant(grant),
	.out_en(out_en)
);

`default_nettype wire

//--- verif/mc_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mc_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/multicore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module multicore (
	input logic clk,
	input logic rst_n,
	input mc_pkg::sample_t io_in,
	input logic in_load,
	output logic req_any,
	output mc_pkg::core_idx_t req_core,
	output mc_pkg::result_t io_out,
	output mc_pkg::code_t out_en,
	output mc_pkg::core_idx_t out_core
);
	import mc_pkg::*;

	logic [`MC_NUM_CORES-1:0] core_rst_n;
	logic [`MC_NUM_CORES-1:0] load;
	logic [`MC_NUM_CORES-1:0] grant;
	code_t req_code [0:`MC_NUM_CORES-1];
	result_t res [0:`MC_NUM_CORES-1];
	code_t out_code [0:`MC_NUM_CORES-1];

	reset_sequencer u_rst_seq (
		.clk(clk),
		.rst_n(rst_n),
		.core_rst_n(core_rst_n)
	);

	// all cores share the sample bus
	for (genvar i = 0; i < `MC_NUM_CORES; i++) begin : g_core
		taylor_core u_core (
			.clk(clk),
			.rst_n(core_rst_n[i]),
			.load(load[i]),
			.io_in(io_in),
			.grant(grant[i]),
			.req_code(req_code[i]),
			.res(res[i]),
			.out_code(out_code[i])
		);
	end

	core_arbiter u_arb (
		.req_code(req_code),
		.res(res),
		.out_code(out_code),
		.in_load(in_load),
		.load(load),
		.grant(grant),
		.req_any(req_any),
		.req_core(req_core),
		.io_out(io_out),
		.out_en(out_en),
		.out_core(out_core)
	);

endmodule

`default_nettype wire

//--- logic/core_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module core_arbiter (
	input mc_pkg::code_t req_code [0:`MC_NUM_CORES-1],
	input mc_pkg::result_t res [0:`MC_NUM_CORES-1],
	input mc_pkg::code_t out_code [0:`MC_NUM_CORES-1],
	input logic in_load,
	output logic [`MC_NUM_CORES-1:0] load,
	output logic [`MC_NUM_CORES-1:0] grant,
	output logic req_any,
	output mc_pkg::core_idx_t req_core,
	output mc_pkg::result_t io_out,
	output mc_pkg::code_t out_en,
	output mc_pkg::core_idx_t out_core
);
	import mc_pkg::*;

	// lowest requesting core takes the sample
	always_comb begin
		logic found;
		found = 1'b0;
		load = '0;
		req_core = '0;
		for (int i = 0; i < `MC_NUM_CORES; i++) begin
			if (!found && req_code[i] == REQ_SAMPLE) begin
				found = 1'b1;
				req_core = core_idx_t'(i);
				load[i] = in_load;
			end
		end
		req_any = found;
	end

	// lowest holding core drives the result bus
	always_comb begin
		logic found;
		found = 1'b0;
		grant = '0;
		io_out = '0;
		out_en = CODE_NONE;
		out_core = '0;
		for (int i = 0; i < `MC_NUM_CORES; i++) begin
			if (!found && out_code[i] != CODE_NONE) begin
				found = 1'b1;
				grant[i] = 1'b1;
				io_out = res[i];
				out_en = out_code[i];
				out_core = core_idx_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/taylor_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module taylor_core (
	input logic clk,
	input logic rst_n,
	input logic load,
	input mc_pkg::sample_t io_in,
	input logic grant,
	output mc_pkg::code_t req_code,
	output mc_pkg::result_t res,
	output mc_pkg::code_t out_code
);
	import mc_pkg::*;

	localparam int RES_W = $bits(result_t);
	localparam int ACC_W = RES_W + 4; // guard bits for overflow detection
	localparam int X_W = $bits(sample_t);
	localparam int PROD_W = ACC_W + X_W;
	localparam int CNT_W = $clog2(`MC_ORDER + 1);

	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [`MC_ORDER:0][ACC_W-1:0] coef_tab_t;

	// entry k holds 1/k! in Q7.24, truncated
	function automatic coef_tab_t coef_table();
		coef_tab_t tab;
		longint fact;
		fact = 1;
		for (int k = 0; k <= `MC_ORDER; k++) begin
			if (k > 0)
				fact = fact * k;
			tab[k] = ACC_W'((64'sd1 <<< `MC_Y_FRAC) / fact);
		end
		return tab;
	endfunction

	localparam coef_tab_t COEF = coef_table();

	core_state_t state;
	logic [CNT_W-1:0] cnt; // steps left, zero means saturate
	logic [CNT_W-1:0] coef_idx;
	sample_t x_q;
	acc_t acc;
	acc_t coef;
	acc_t step_acc;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W:0] step_sum;
	result_t sat_res;
	logic sat_hit;

	assign coef_idx = (cnt == '0) ? '0 : cnt - 1'b1;
	assign coef = COEF[coef_idx];

	// one Horner step, truncating shift
	assign prod = acc * x_q;
	assign step_sum = (prod >>> `MC_X_FRAC) + coef;

	always_comb begin
		if (step_sum[PROD_W:ACC_W-1] == '0 || step_sum[PROD_W:ACC_W-1] == '1)
			step_acc = step_sum[ACC_W-1:0];
		else if (step_sum[PROD_W])
			step_acc = {1'b1, {(ACC_W-1){1'b0}}};
		else
			step_acc = {1'b0, {(ACC_W-1){1'b1}}};
	end

	// clamp to result range
	always_comb begin
		sat_hit = !(acc[ACC_W-1:RES_W-1] == '0 || acc[ACC_W-1:RES_W-1] == '1);
		if (!sat_hit)
			sat_res = acc[RES_W-1:0];
		else if (acc[ACC_W-1])
			sat_res = {1'b1, {(RES_W-1){1'b0}}};
		else
			sat_res = {1'b0, {(RES_W-1){1'b1}}};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= REQUEST;
			req_code <= CODE_NONE;
			out_code <= CODE_NONE;
			cnt <= '0;
		end else begin
			case (state)
				REQUEST: begin
					if (load) begin
						req_code <= CODE_NONE;
						cnt <= CNT_W'(`MC_ORDER);
						state <= STEP;
					end else begin
						req_code <= REQ_SAMPLE;
					end
				end
				STEP: begin
					if (cnt == '0) begin
						out_code <= sat_hit ? OUT_SATURATED : OUT_RESULT;
						state <= HOLD;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				HOLD: begin
					if (grant) begin // delivered this cycle
						out_code <= CODE_NONE;
						state <= REQUEST;
					end
				end
				default: state <= REQUEST;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == REQUEST && load) begin
			x_q <= io_in;
			acc <= COEF[`MC_ORDER]; // start from highest coefficient
		end else if (state == STEP && cnt != '0) begin
			acc <= step_acc;
		end
		if (state == STEP && cnt == '0)
			res <= sat_res;
	end

endmodule

`default_nettype wire

//--- logic/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mc_defs.svh"

module reset_sequencer (
	input logic clk,
	input logic rst_n,
	output logic [`MC_NUM_CORES-1:0] core_rst_n
);

	localparam int STAGE_W = $clog2(`MC_NUM_CORES + 1);
	localparam int CYC_W = $clog2(`MC_STAGGER_CYCLES + 1);

	logic [STAGE_W-1:0] stage; // highest core allowed out of reset
	logic [CYC_W-1:0] cyc;

	// core k comes out k stagger periods after the first edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= '0;
			cyc <= '0;
			core_rst_n <= '0;
		end else begin
			for (int k = 0; k < `MC_NUM_CORES; k++) begin
				core_rst_n[k] <= (int'(stage) >= k);
			end
			if (int'(stage) < `MC_NUM_CORES - 1) begin // stops once all released
				if (int'(cyc) == `MC_STAGGER_CYCLES - 1) begin
					cyc <= '0;
					stage <= stage + 1'b1;
				end else begin
					cyc <= cyc + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/mc_pkg.sv
`default_nettype none

`include "mc_defs.svh"

package mc_pkg;

	localparam int CORE_IDX_W = (`MC_NUM_CORES > 1) ? $clog2(`MC_NUM_CORES) : 1;

	typedef logic signed [`MC_X_FRAC+3:0] sample_t; // Q3.15
	typedef logic signed [`MC_Y_FRAC+3:0] result_t; // Q3.24
	typedef logic [3:0] code_t;
	typedef logic [CORE_IDX_W-1:0] core_idx_t;

	typedef enum logic [1:0] {
		REQUEST,
		STEP,
		HOLD
	} core_state_t;

	// request field
	localparam code_t CODE_NONE = 4'd0;
	localparam code_t REQ_SAMPLE = 4'd1;

	// output enable field
	localparam code_t OUT_RESULT = 4'd1;
	localparam code_t OUT_SATURATED = 4'd2;

endpackage

`default_nettype wire

//--- logic/mc_defs.svh
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// array size
`define MC_NUM_CORES 4

// cycles between two core reset releases
`define MC_STAGGER_CYCLES 25

// fraction bits of the input sample
`define MC_X_FRAC 15

// fraction bits of the result and coefficients
`define MC_Y_FRAC 24

// number of Horner steps per evaluation
`define MC_ORDER 4

`endif
